// ==== tb.f ====
+incdir+source
+incdir+verif
source/settings_pkg.sv
source/frontend_pkg.sv
source/cmd_decoder.sv
source/timekeeper.sv
source/frontend_io.sv
source/readback_responder.sv
source/radio_core.sv
verif/radio_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the radio core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module radio_core_tb -o radio_core_sim
./obj_dir/radio_core_sim | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== verif/radio_cmd_table.svh ====
// Radio core command table
// Rows of pin drive values, one command or wait each, and expectations

`ifndef RADIO_CMD_TABLE_SVH
`define RADIO_CMD_TABLE_SVH

localparam logic [2:0] K_WR    = 3'd0;  // Setting write
localparam logic [2:0] K_RD    = 3'd1;  // Read, o_resp within win of exp
localparam logic [2:0] K_FE    = 3'd2;  // o_tx against exp, o_rx_sample against exp_rx
localparam logic [2:0] K_IDLE  = 3'd3;  // Drive pins only
localparam logic [2:0] K_STALL = 3'd4;  // Two reads under back-pressure

typedef struct packed {
   logic [2:0]            kind;
   logic [`SR_ADDR_W-1:0] addr;
   logic [`SR_DATA_W-1:0] data;
   logic [47:0]           tx_sample;
   logic [31:0]           rx;
   logic                  pps;
   logic [`RESP_W-1:0]    exp;
   logic [47:0]           exp_rx;
   logic [15:0]           win;       // Allowed count ahead of exp
} row_t;

row_t        rows[$];
logic [47:0] cur_tx;
logic [31:0] cur_rx;
logic        cur_pps;

task automatic add_row(input logic [2:0] kind, input logic [7:0] addr,
                       input logic [31:0] data, input logic [63:0] exp,
                       input logic [47:0] exp_rx, input logic [15:0] win);
   rows.push_back('{kind, addr, data, cur_tx, cur_rx, cur_pps, exp, exp_rx, win});
endtask

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
   end
endtask

task automatic build_table();
   logic [31:0] w;
   int          n;
   cur_tx  = 48'hABCDEF_135791;
   cur_rx  = 32'h1234_5678;
   cur_pps = 1'b0;
   add_row(K_WR, `SR_READBACK, 32'd0, 64'd0, 48'd0, 16'd0);
   for (n = 0; n < 3; n++) begin
      w = $urandom;
      add_row(K_WR, `SR_TEST, w, 64'd0, 48'd0, 16'd0);
      add_row(K_RD, 8'd0, 32'd0, {32'd0, w}, 48'd0, 16'd0);
   end
   // TX idle, run and loopback
   add_row(K_WR, `SR_CODEC_IDLE, 32'hDEAD_BEEF, 64'd0, 48'd0, 16'd0);
   add_row(K_FE, 8'd0, 32'd0, 64'hDEAD_BEEF, 48'h123400_567800, 16'd0);
   add_row(K_WR, `SR_TX_CTRL, 32'd1, 64'd0, 48'd0, 16'd0);
   add_row(K_FE, 8'd0, 32'd0, 64'hABCD_1357, 48'h123400_567800, 16'd0);
   add_row(K_WR, `SR_LOOPBACK, 32'd1, 64'd0, 48'd0, 16'd0);
   add_row(K_FE, 8'd0, 32'd0, 64'hABCD_1357, 48'hABCD00_135700, 16'd0);
   add_row(K_WR, `SR_READBACK, 32'd3, 64'd0, 48'd0, 16'd0);
   add_row(K_RD, 8'd0, 32'd0, 64'hABCD_1357_1234_5678, 48'd0, 16'd0);
   add_row(K_STALL, 8'd0, 32'd0, 64'hABCD_1357_1234_5678, 48'd0, 16'd0);
   cur_rx = 32'h0F0F_A5A5;
   add_row(K_WR, `SR_LOOPBACK, 32'd0, 64'd0, 48'd0, 16'd0);
   add_row(K_WR, `SR_TX_CTRL, 32'd0, 64'd0, 48'd0, 16'd0);
   add_row(K_FE, 8'd0, 32'd0, 64'hDEAD_BEEF, 48'h0F0F00_A5A500, 16'd0);
   // Immediate load, then a PPS armed load
   add_row(K_WR, `SR_TIME_HI, 32'h0000_0012, 64'd0, 48'd0, 16'd0);
   add_row(K_WR, `SR_TIME_LO, 32'h3456_0000, 64'd0, 48'd0, 16'd0);
   add_row(K_WR, `SR_TIME_CTRL, 32'd0, 64'd0, 48'd0, 16'd0);
   add_row(K_WR, `SR_READBACK, 32'd1, 64'd0, 48'd0, 16'd0);
   add_row(K_RD, 8'd0, 32'd0, 64'h12_3456_0000, 48'd0, 16'd40);
   add_row(K_WR, `SR_TIME_HI, 32'h0000_00AB, 64'd0, 48'd0, 16'd0);
   add_row(K_WR, `SR_TIME_LO, 32'h0000_0000, 64'd0, 48'd0, 16'd0);
   add_row(K_WR, `SR_TIME_CTRL, 32'd1, 64'd0, 48'd0, 16'd0);
   add_row(K_RD, 8'd0, 32'd0, 64'h12_3456_0000, 48'd0, 16'd100);  // Still old count
   cur_pps = 1'b1;
   add_row(K_IDLE, 8'd0, 32'd0, 64'd0, 48'd0, 16'd0);
   cur_pps = 1'b0;
   add_row(K_RD, 8'd0, 32'd0, 64'hAB_0000_0000, 48'd0, 16'd40);
   add_row(K_WR, `SR_READBACK, 32'd2, 64'd0, 48'd0, 16'd0);
   add_row(K_RD, 8'd0, 32'd0, 64'h12_3456_0000, 48'd0, 16'd160);
endtask

`endif

// ==== verif/radio_core_tb.sv ====
// Radio control core testbench
// Walks the command table through the core, checks responses and pins

`timescale 1ns/1ns

`include "radio_macros.svh"

module radio_core_tb;

   localparam int CLK_PERIOD   = 4;
   localparam int ROW_CYCLES   = 40;   // Bound for the longest row
   localparam int STALL_CYCLES = 6;

   logic                    bus_clk = 1'b0;
   logic                    i_arst_n;
   settings_pkg::cmd_word_t i_ctrl;
   logic                    i_ctrl_valid;
   logic                    o_ctrl_ready;
   logic [`RESP_W-1:0]      o_resp;
   logic                    o_resp_valid;
   logic                    i_resp_ready;
   logic                    i_pps;
   frontend_pkg::iq24_t     i_tx_sample;
   frontend_pkg::iq16_t     i_rx;
   frontend_pkg::iq16_t     o_tx;
   frontend_pkg::iq24_t     o_rx_sample;
   logic                    table_ready = 1'b0;

   `include "radio_cmd_table.svh"

   radio_core dut0 (.*);

   always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

   //////////////////////////////////////////////////
   // Handshake tasks
   //////////////////////////////////////////////////
   task automatic wait_accept();
      @(negedge bus_clk);
      while (!o_ctrl_ready) @(negedge bus_clk);
      @(posedge bus_clk);                 // Word taken here
      i_ctrl_valid <= 1'b0;
   endtask

   task automatic send_cmd(input settings_pkg::cmd_op_e cmd_op, input logic [7:0] addr,
                           input logic [31:0] data);
      @(posedge bus_clk);
      i_ctrl       <= '{op: cmd_op, rsvd: '0, addr: addr, data: data};
      i_ctrl_valid <= 1'b1;
      wait_accept();
   endtask

   task automatic get_resp(output logic [63:0] resp);
      @(negedge bus_clk);
      while (!o_resp_valid) @(negedge bus_clk);
      resp = o_resp;
      @(posedge bus_clk);
   endtask

   //////////////////////////////////////////////////
   // Row checks
   //////////////////////////////////////////////////
   task automatic expect_read(input row_t r);
      logic [63:0] got;
      send_cmd(settings_pkg::OP_READ, 8'd0, 32'd0);
      get_resp(got);
      // Anything from exp to exp plus win passes
      if (got < r.exp || got - r.exp > 64'(r.win)) begin
         check_value("o_resp", got, r.exp);
      end
   endtask

   task automatic expect_frontend(input row_t r);
      repeat (3) @(posedge bus_clk);
      @(negedge bus_clk);
      check_value("o_tx", 64'(o_tx), r.exp);
      check_value("o_rx_sample", 64'(o_rx_sample), 64'(r.exp_rx));
   endtask

   task automatic stall_reads(input row_t r);
      logic [63:0] held;
      logic [63:0] got;
      i_resp_ready <= 1'b0;
      send_cmd(settings_pkg::OP_READ, 8'd0, 32'd0);
      @(negedge bus_clk);
      while (!o_resp_valid) @(negedge bus_clk);
      held = o_resp;
      @(posedge bus_clk);
      i_rx         <= ~r.rx;              // Second read must see this
      i_ctrl       <= '{op: settings_pkg::OP_READ, rsvd: '0, addr: '0, data: '0};
      i_ctrl_valid <= 1'b1;
      repeat (STALL_CYCLES) begin
         @(negedge bus_clk);
         check_value("o_ctrl_ready", 64'(o_ctrl_ready), 64'd0);
         check_value("o_resp_valid", 64'(o_resp_valid), 64'd1);
         check_value("o_resp", o_resp, held);
      end
      check_value("o_resp", held, r.exp);
      @(posedge bus_clk);
      i_resp_ready <= 1'b1;
      wait_accept();
      get_resp(got);
      check_value("o_resp", got, {r.exp[63:32], ~r.rx});
   endtask

   //////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////
   initial begin
      row_t r;
      int   idx;
      void'($urandom(32'h6a15d838));
      i_arst_n     = 1'b0;
      i_ctrl       = '0;
      i_ctrl_valid = 1'b0;
      i_resp_ready = 1'b1;
      i_pps        = 1'b0;
      i_tx_sample  = '0;
      i_rx         = '0;
      build_table();
      table_ready = 1'b1;
      repeat (16) @(posedge bus_clk);
      i_arst_n <= 1'b1;
      @(negedge bus_clk);
      check_value("o_resp_valid", 64'(o_resp_valid), 64'd0);
      check_value("o_ctrl_ready", 64'(o_ctrl_ready), 64'd1);
      for (idx = 0; idx < rows.size(); idx++) begin
         r = rows[idx];
         @(posedge bus_clk);
         i_tx_sample <= r.tx_sample;
         i_rx        <= r.rx;
         i_pps       <= r.pps;
         case (r.kind)
            K_WR:    send_cmd(settings_pkg::OP_WRITE, r.addr, r.data);
            K_RD:    expect_read(r);
            K_FE:    expect_frontend(r);
            K_IDLE:  repeat (4) @(posedge bus_clk);
            K_STALL: stall_reads(r);
            default: begin
               $display("Table row %0d has an unknown kind", idx);
               $display("FAIL: see errors above");
               $fatal(1);
            end
         endcase
      end
      $display("PASS: all tests");
      $finish;
   end

   initial begin
      wait (table_ready);
      #((rows.size() * ROW_CYCLES + 32) * CLK_PERIOD);
      $display("Timeout: the command table did not finish, the DUT stopped handshaking");
      $display("FAIL: see errors above");
      $fatal(1);
   end

endmodule

// ==== source/radio_core.sv ====
// Radio control core top level
// Command decode feeding the timekeeper, front end and readback

`timescale 1ns/1ns

`include "radio_macros.svh"

module radio_core (
   input  logic                    bus_clk,
   input  logic                    i_arst_n,
   // Command stream
   input  settings_pkg::cmd_word_t i_ctrl,
   input  logic                    i_ctrl_valid,
   output logic                    o_ctrl_ready,
   // Response stream
   output logic [`RESP_W-1:0]      o_resp,
   output logic                    o_resp_valid,
   input  logic                    i_resp_ready,
   // Timing and converter side
   input  logic                    i_pps,
   input  frontend_pkg::iq24_t     i_tx_sample,
   input  frontend_pkg::iq16_t     i_rx,
   output frontend_pkg::iq16_t     o_tx,
   output frontend_pkg::iq24_t     o_rx_sample
);

   settings_pkg::set_bus_t   set_bus;
   logic                     rd_req;
   logic                     resp_busy;
   frontend_pkg::time_info_t time_info;

   cmd_decoder u_cmd_decoder (
      .bus_clk      (bus_clk),
      .i_arst_n     (i_arst_n),
      .i_ctrl       (i_ctrl),
      .i_ctrl_valid (i_ctrl_valid),
      .o_ctrl_ready (o_ctrl_ready),
      .i_resp_busy  (resp_busy),
      .o_set        (set_bus),
      .o_rd_req     (rd_req)
   );

   timekeeper u_timekeeper (
      .bus_clk  (bus_clk),
      .i_arst_n (i_arst_n),
      .i_set    (set_bus),
      .i_pps    (i_pps),
      .o_time   (time_info)
   );

   frontend_io u_frontend_io (
      .bus_clk     (bus_clk),
      .i_arst_n    (i_arst_n),
      .i_set       (set_bus),
      .i_tx_sample (i_tx_sample),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .o_rx_sample (o_rx_sample)
   );

   // Frontend slot reports the converter words as seen on the pins
   readback_responder u_readback_responder (
      .bus_clk      (bus_clk),
      .i_arst_n     (i_arst_n),
      .i_set        (set_bus),
      .i_rd_req     (rd_req),
      .i_time       (time_info),
      .i_tx         (o_tx),
      .i_rx         (i_rx),
      .o_resp       (o_resp),
      .o_resp_valid (o_resp_valid),
      .i_resp_ready (i_resp_ready),
      .o_busy       (resp_busy)
   );

endmodule

// ==== source/readback_responder.sv ====
// Readback responder
// Test and slot-select registers, readback mux and a response
// register that holds each answer until the host takes it

`timescale 1ns/1ns

`include "radio_macros.svh"

module readback_responder (
   input  logic                      bus_clk,
   input  logic                      i_arst_n,
   input  settings_pkg::set_bus_t    i_set,
   input  logic                      i_rd_req,
   input  frontend_pkg::time_info_t  i_time,
   input  frontend_pkg::iq16_t       i_tx,
   input  frontend_pkg::iq16_t       i_rx,
   output logic [`RESP_W-1:0]        o_resp,
   output logic                      o_resp_valid,
   input  logic                      i_resp_ready,
   output logic                      o_busy
);

   logic [`SR_DATA_W-1:0] test_q;
   frontend_pkg::rb_sel_e rb_sel_q;
   logic                  rd_pend_q;  // Request seen, capture next edge
   logic [`RESP_W-1:0]    rb_data;

   //////////////////////////////////////////////////
   // Setting registers
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         test_q   <= '0;
         rb_sel_q <= frontend_pkg::RB_TEST;
      end else if (i_set.stb) begin
         if (i_set.addr == `SR_TEST) begin
            test_q <= i_set.data;
         end
         if (i_set.addr == `SR_READBACK) begin
            rb_sel_q <= frontend_pkg::rb_sel_e'(i_set.data[2:0]);
         end
      end
   end

   //////////////////////////////////////////////////
   // Readback mux
   //////////////////////////////////////////////////
   always_comb begin
      case (rb_sel_q)
         frontend_pkg::RB_TEST:     rb_data = {{(`RESP_W-`SR_DATA_W){1'b0}}, test_q};
         frontend_pkg::RB_TIME:     rb_data = i_time.now;
         frontend_pkg::RB_LASTPPS:  rb_data = i_time.lastpps;
         frontend_pkg::RB_FRONTEND: rb_data = {i_tx, i_rx};
         default:                   rb_data = '0;  // Unused slots
      endcase
   end

   //////////////////////////////////////////////////
   // Response register
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rd_pend_q    <= 1'b0;
         o_resp       <= '0;
         o_resp_valid <= 1'b0;
      end else begin
         rd_pend_q <= i_rd_req;
         if (rd_pend_q) begin
            // Decoder holds off new commands, so no overlap with a held word
            o_resp       <= rb_data;
            o_resp_valid <= 1'b1;
         end else if (o_resp_valid && i_resp_ready) begin
            o_resp_valid <= 1'b0;
         end
      end
   end

   // Keeps the decoder stalled from request until handoff
   assign o_busy = rd_pend_q | o_resp_valid;

endmodule

// ==== source/frontend_io.sv ====
// Front-end I/O
// Loopback, codec idle and run registers, registered TX word
// and RX sample path with optional digital loopback

`timescale 1ns/1ns

`include "radio_macros.svh"

module frontend_io (
   input  logic                    bus_clk,
   input  logic                    i_arst_n,
   input  settings_pkg::set_bus_t  i_set,
   input  frontend_pkg::iq24_t     i_tx_sample,
   input  frontend_pkg::iq16_t     i_rx,
   output frontend_pkg::iq16_t     o_tx,
   output frontend_pkg::iq24_t     o_rx_sample
);

   localparam int PAD_W = `SAMPLE_W - `FE_W;

   logic                  loopback_q;
   logic                  run_q;
   logic [`SR_DATA_W-1:0] idle_q;    // Driven to converter when not running
   frontend_pkg::iq16_t   tx_next;
   frontend_pkg::iq16_t   rx_src;

   //////////////////////////////////////////////////
   // Control registers
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         loopback_q <= 1'b0;
         run_q      <= 1'b0;
         idle_q     <= '0;
      end else if (i_set.stb) begin
         if (i_set.addr == `SR_LOOPBACK)   loopback_q <= i_set.data[0];
         if (i_set.addr == `SR_TX_CTRL)    run_q      <= i_set.data[0];
         if (i_set.addr == `SR_CODEC_IDLE) idle_q     <= i_set.data;
      end
   end

   //////////////////////////////////////////////////
   // Sample paths
   //////////////////////////////////////////////////
   always_comb begin
      if (run_q) begin
         tx_next.i = i_tx_sample.i[`SAMPLE_W-1 -: `FE_W];  // Keep top bits
         tx_next.q = i_tx_sample.q[`SAMPLE_W-1 -: `FE_W];
      end else begin
         tx_next = frontend_pkg::iq16_t'(idle_q);
      end
   end

   assign rx_src = loopback_q ? o_tx : i_rx;

   always_ff @(posedge bus_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_tx        <= '0;
         o_rx_sample <= '0;
      end else begin
         o_tx          <= tx_next;
         o_rx_sample.i <= {rx_src.i, {PAD_W{1'b0}}};
         o_rx_sample.q <= {rx_src.q, {PAD_W{1'b0}}};
      end
   end

endmodule

// ==== source/timekeeper.sv ====
// Timekeeper
// Free-running 64-bit time counter, loaded at once or on the
// next PPS rising edge, and a latch of the time at each PPS

`timescale 1ns/1ns

`include "radio_macros.svh"

module timekeeper (
   input  logic                      bus_clk,
   input  logic                      i_arst_n,
   input  settings_pkg::set_bus_t    i_set,
   input  logic                      i_pps,
   output frontend_pkg::time_info_t  o_time
);

   logic [`SR_DATA_W-1:0] time_hi_q;
   logic [`SR_DATA_W-1:0] time_lo_q;
   logic [`TIME_W-1:0]    time_q;
   logic [`TIME_W-1:0]    lastpps_q;
   logic                  arm_q;      // Load pending on next PPS
   logic                  pps_d;
   logic                  pps_rise;
   logic                  ctrl_wr;

   assign pps_rise = i_pps & ~pps_d;
   assign ctrl_wr  = i_set.stb & (i_set.addr == `SR_TIME_CTRL);

   //////////////////////////////////////////////////
   // Load value registers
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         time_hi_q <= '0;
         time_lo_q <= '0;
      end else if (i_set.stb) begin
         if (i_set.addr == `SR_TIME_HI) time_hi_q <= i_set.data;
         if (i_set.addr == `SR_TIME_LO) time_lo_q <= i_set.data;
      end
   end

   //////////////////////////////////////////////////
   // Counter, arm flag and PPS latch
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         time_q    <= '0;
         lastpps_q <= '0;
         arm_q     <= 1'b0;
         pps_d     <= 1'b0;
      end else begin
         pps_d <= i_pps;

         if (pps_rise) begin
            lastpps_q <= time_q;
         end

         if (ctrl_wr && !i_set.data[0]) begin
            time_q <= {time_hi_q, time_lo_q};  // Immediate load
            arm_q  <= 1'b0;
         end else if (ctrl_wr) begin
            time_q <= time_q + 1'b1;
            arm_q  <= 1'b1;                    // Wait for PPS
         end else if (arm_q && pps_rise) begin
            time_q <= {time_hi_q, time_lo_q};
            arm_q  <= 1'b0;
         end else begin
            time_q <= time_q + 1'b1;
         end
      end
   end

   assign o_time = '{now: time_q, lastpps: lastpps_q};

endmodule

// ==== source/cmd_decoder.sv ====
// Command decoder
// Takes 64-bit command words and turns them into setting-bus
// writes or readback requests, stalling while a read is open

`timescale 1ns/1ns

module cmd_decoder (
   input  logic                   bus_clk,
   input  logic                   i_arst_n,
   input  settings_pkg::cmd_word_t i_ctrl,
   input  logic                   i_ctrl_valid,
   output logic                   o_ctrl_ready,
   input  logic                   i_resp_busy,
   output settings_pkg::set_bus_t o_set,
   output logic                   o_rd_req
);

   settings_pkg::cmd_word_t cmd_q;
   logic                    cmd_vld_q;   // Word taken last edge
   logic                    accept;
   logic                    rd_pending;

   //////////////////////////////////////////////////
   // Handshake
   //////////////////////////////////////////////////
   assign accept = i_ctrl_valid & o_ctrl_ready;

   // Read in flight until responder takes over as busy
   assign rd_pending = cmd_vld_q & (cmd_q.op == settings_pkg::OP_READ);

   assign o_ctrl_ready = ~rd_pending & ~i_resp_busy;

   //////////////////////////////////////////////////
   // Command register
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cmd_q     <= '0;
         cmd_vld_q <= 1'b0;
      end else begin
         cmd_vld_q <= accept;
         if (accept) begin
            cmd_q <= i_ctrl;
         end
      end
   end

   //////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////
   // Write strobe lives for the single cycle after acceptance
   assign o_set.stb  = cmd_vld_q & (cmd_q.op == settings_pkg::OP_WRITE);
   assign o_set.addr = cmd_q.addr;
   assign o_set.data = cmd_q.data;

   assign o_rd_req = rd_pending;  // One-cycle pulse

endmodule

// ==== source/frontend_pkg.sv ====
// Front-end and time types
// Sample formats, time bundle and readback slot encoding

`include "radio_macros.svh"

package frontend_pkg;

   // Full precision DSP sample
   typedef struct packed {
      logic [`SAMPLE_W-1:0] i;
      logic [`SAMPLE_W-1:0] q;
   } iq24_t;

   // Converter word, I in the high half
   typedef struct packed {
      logic [`FE_W-1:0] i;
      logic [`FE_W-1:0] q;
   } iq16_t;

   typedef struct packed {
      logic [`TIME_W-1:0] now;
      logic [`TIME_W-1:0] lastpps;  // Time seen at last PPS edge
   } time_info_t;

   // Readback slots, others read as zero
   typedef enum logic [2:0] {
      RB_TEST     = 3'd0,
      RB_TIME     = 3'd1,
      RB_LASTPPS  = 3'd2,
      RB_FRONTEND = 3'd3
   } rb_sel_e;

endpackage

// ==== source/settings_pkg.sv ====
// Setting-bus and command types
// Command word layout and the decoded write strobe bundle

`include "radio_macros.svh"

package settings_pkg;

   // Command opcode in bit 63
   typedef enum logic {
      OP_WRITE = 1'b0,
      OP_READ  = 1'b1
   } cmd_op_e;

   // 64-bit command from the control stream
   typedef struct packed {
      cmd_op_e                op;
      logic [22:0]            rsvd;   // Ignored
      logic [`SR_ADDR_W-1:0]  addr;
      logic [`SR_DATA_W-1:0]  data;
   } cmd_word_t;

   // One setting-bus write
   typedef struct packed {
      logic                   stb;
      logic [`SR_ADDR_W-1:0]  addr;
      logic [`SR_DATA_W-1:0]  data;
   } set_bus_t;

endpackage

// ==== source/radio_macros.svh ====
// Radio control core register map
// Setting-bus addresses and the shared datapath widths

`ifndef RADIO_MACROS_SVH
`define RADIO_MACROS_SVH

//////////////////////////////////////////////////
// Setting-bus addresses
//////////////////////////////////////////////////
`define SR_LOOPBACK   8'd6    // TX to RX digital loopback
`define SR_TEST       8'd21   // Scratch word for readback
`define SR_CODEC_IDLE 8'd22
`define SR_READBACK   8'd32   // Readback slot select
`define SR_TX_CTRL    8'd64   // Bit 0 is run
`define SR_TIME_HI    8'd128
`define SR_TIME_LO    8'd129
`define SR_TIME_CTRL  8'd130  // Bit 0 arms load on PPS

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////
`define SR_ADDR_W     8
`define SR_DATA_W     32
`define TIME_W        64
`define SAMPLE_W      24      // DSP side I or Q
`define FE_W          16      // Converter side I or Q
`define RESP_W        64

`endif
